// File: bench/cache_tb.sv
`include "cache_settings.svh"

module cache_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cache_pkg::*;

  localparam int CLK_NS     = 20;
  localparam int N_DIRECTED = 17;
  localparam int N_RANDOM   = 400;
  localparam int N_ACCESS   = N_DIRECTED + N_RANDOM;
  // worst case per access is a dirty miss, a few spare cycles cover reset
  localparam int TIMEOUT_NS = (N_ACCESS * (2 * `MEM_LATENCY + 8) + 4) * CLK_NS;
  localparam int MEM_WORDS  = 1024;  // 4 KiB of shadow memory

  logic  clk;
  logic  reset;
  logic  in_valid;
  addr_t addr;
  logic  write;
  word_t wdata;
  logic  ready;
  logic  out_valid;
  word_t rdata;
  logic  hit;

  int    value_errors;
  int    proto_errors;
  int    timeout_errors;
  string test_name;
  word_t rng_state;
  word_t last_rdata;   // captured by the stimulus at out_valid
  logic  last_hit;

  word_t exp_rdata_q[$];
  logic  exp_hit_q[$];

  // reference model state
  word_t shadow_mem   [MEM_WORDS];
  tag_t  shadow_tag   [`CACHE_SETS][`CACHE_WAYS];
  logic  shadow_valid [`CACHE_SETS][`CACHE_WAYS];
  way_t  shadow_lru   [`CACHE_SETS];

  cache_top dut_i (
    .clk, .reset,
    .in_valid, .addr, .write, .wdata,
    .ready, .out_valid, .rdata, .hit
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // 2-way set model, invalid way 0 then way 1, else lru
  function automatic void model_access(input addr_t a, input logic wr, input word_t d,
                                       output word_t exp_rdata, output logic exp_hit);
    index_t idx;
    tag_t   tg;
    way_t   way;
    int     widx;
    idx     = a[6:4];
    tg      = a[31:7];
    widx    = int'(a[11:2]);
    exp_hit = 1'b0;
    way     = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (!exp_hit && shadow_valid[idx][w] && shadow_tag[idx][w] == tg) begin
        exp_hit = 1'b1;
        way     = way_t'(w);
      end
    end
    if (!exp_hit) begin
      if (!shadow_valid[idx][0])
        way = 1'b0;
      else if (!shadow_valid[idx][1])
        way = 1'b1;
      else
        way = shadow_lru[idx];
      shadow_valid[idx][way] = 1'b1;
      shadow_tag[idx][way]   = tg;
    end
    shadow_lru[idx] = ~way;  // other way is now least recent
    if (wr)
      shadow_mem[widx] = d;
    exp_rdata = shadow_mem[widx];
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      value_errors++;
      $display("Fail %s: rdata expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_hit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      value_errors++;
      $display("Fail %s: hit expected %b, actual %b", name, exp, act);
    end
  endtask

  // explicit expectation for a directed step
  task automatic check_last(input logic exp_hit, input word_t exp_word);
    check_hit(test_name, exp_hit, last_hit);
    check_word(test_name, exp_word, last_rdata);
  endtask

  // one request through the handshake, starting on a falling edge
  task automatic run_access(input addr_t a, input logic wr, input word_t d);
    word_t exp_rdata;
    logic  exp_hit;
    int    cycles;
    while (!ready)
      @(negedge clk);
    model_access(a, wr, d, exp_rdata, exp_hit);
    exp_rdata_q.push_back(exp_rdata);
    exp_hit_q.push_back(exp_hit);
    in_valid = 1'b1;
    addr     = a;
    write    = wr;
    wdata    = d;
    @(negedge clk);
    in_valid = 1'b0;
    cycles   = 0;
    while (!out_valid) begin
      if (ready) begin
        proto_errors++;
        $display("%s: ready went high before the response to %h", test_name, a);
      end
      @(negedge clk);
      cycles++;
    end
    if (ready) begin
      proto_errors++;
      $display("%s: ready was high during the response cycle", test_name);
    end
    last_rdata = rdata;
    last_hit   = hit;
    if (hit && cycles != 1) begin
      value_errors++;
      $display("Fail %s: hit latency expected %0d, actual %0d", test_name, 1, cycles);
    end
    @(negedge clk);
    if (!ready) begin
      proto_errors++;
      $display("%s: ready did not return the cycle after the response", test_name);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d value, %0d protocol, %0d timeout",
             value_errors, proto_errors, timeout_errors);
    if (value_errors + proto_errors + timeout_errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  endtask

  // compare every response against the model
  always @(negedge clk) begin
    if (!reset && out_valid) begin
      if (exp_rdata_q.size() == 0) begin
        proto_errors++;
        $display("%s: a response came with no request outstanding", test_name);
      end else begin
        check_word(test_name, exp_rdata_q.pop_front(), rdata);
        check_hit(test_name, exp_hit_q.pop_front(), hit);
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    timeout_errors++;
    $display("timeout: the cache stopped responding to requests");
    finish_run();
  end

  initial begin
    addr_t a;
    word_t r;
    value_errors   = 0;
    proto_errors   = 0;
    timeout_errors = 0;
    rng_state      = 52211;
    test_name      = "reset";
    reset          = 1'b1;
    in_valid       = 1'b0;
    addr           = '0;
    write          = 1'b0;
    wdata          = '0;
    for (int i = 0; i < MEM_WORDS; i++)
      shadow_mem[i] = word_t'(i * 4);  // each word holds its byte address
    for (int s = 0; s < `CACHE_SETS; s++) begin
      shadow_lru[s] = '0;
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        shadow_valid[s][w] = 1'b0;
        shadow_tag[s][w]   = '0;
      end
    end
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (!ready || out_valid) begin
      proto_errors++;
      $display("reset: ready should be high and out_valid low after reset");
    end

    test_name = "cold_read";  // set 1
    run_access(32'h014, 1'b0, '0);
    check_last(1'b0, 32'h014);
    run_access(32'h014, 1'b0, '0);
    check_last(1'b1, 32'h014);

    test_name = "write_hit";  // set 2
    run_access(32'h020, 1'b0, '0);
    check_last(1'b0, 32'h020);
    run_access(32'h024, 1'b1, 32'h1234_5678);
    check_last(1'b1, 32'h1234_5678);
    run_access(32'h024, 1'b0, '0);
    check_last(1'b1, 32'h1234_5678);
    run_access(32'h028, 1'b0, '0);
    check_last(1'b1, 32'h028);  // neighbour untouched

    test_name = "lru_replace";  // A, B, C all in set 3
    run_access(32'h430, 1'b0, '0);
    check_last(1'b0, 32'h430);
    run_access(32'h4b0, 1'b0, '0);
    check_last(1'b0, 32'h4b0);
    run_access(32'h430, 1'b0, '0);
    check_last(1'b1, 32'h430);
    run_access(32'h530, 1'b0, '0);
    check_last(1'b0, 32'h530);
    run_access(32'h430, 1'b0, '0);
    check_last(1'b1, 32'h430);
    run_access(32'h4b0, 1'b0, '0);
    check_last(1'b0, 32'h4b0);

    test_name = "dirty_evict";  // set 4
    run_access(32'h640, 1'b1, 32'hdead_beef);
    check_last(1'b0, 32'hdead_beef);
    run_access(32'h6c0, 1'b0, '0);
    check_last(1'b0, 32'h6c0);
    run_access(32'h740, 1'b0, '0);  // pushes the dirty line out
    check_last(1'b0, 32'h740);
    run_access(32'h640, 1'b0, '0);
    check_last(1'b0, 32'hdead_beef);
    run_access(32'h644, 1'b0, '0);
    check_last(1'b1, 32'h644);

    test_name = "random_mix";
    for (int n = 0; n < N_RANDOM; n++) begin
      r = next_rand();
      a = addr_t'(r[8:2]) << 2;  // 32 lines, four tags per set
      run_access(a, r[16], next_rand());
    end

    finish_run();
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the cache testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module cache_tb -o cache_tb_sim

status=0
./obj_dir/cache_tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx '>>> PASS' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: src/cache_arrays.sv
`include "cache_settings.svh"

module cache_arrays (
  input  logic              clk,
  input  logic              reset,
  input  cache_pkg::index_t lookup_index,
  input  cache_pkg::tag_t   lookup_tag,
  output cache_pkg::way_t   hit_way,
  output logic              lookup_hit,
  output cache_pkg::way_t   victim_way,
  output logic              victim_dirty,
  output cache_pkg::tag_t   victim_tag,
  output cache_pkg::line_t  hit_line,
  output cache_pkg::line_t  victim_line,
  input  logic              fill_en,
  input  cache_pkg::way_t   fill_way,
  input  cache_pkg::line_t  fill_line,
  input  logic              word_wr_en,
  input  cache_pkg::way_t   word_way,
  input  cache_pkg::offset_t word_offset,
  input  cache_pkg::word_t  word_data,
  input  logic              touch_en,
  input  cache_pkg::way_t   touch_way
);
  import cache_pkg::*;

  tag_t  tag_mem  [`CACHE_SETS][`CACHE_WAYS];
  line_t line_mem [`CACHE_SETS][`CACHE_WAYS];
  logic  valid    [`CACHE_SETS][`CACHE_WAYS];
  logic  dirty    [`CACHE_SETS][`CACHE_WAYS];
  way_t  lru      [`CACHE_SETS];  // names the least recently used way
  logic  free_found;

  // tag compare across the set
  always_comb begin
    lookup_hit = 1'b0;
    hit_way    = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (!lookup_hit && valid[lookup_index][w] && tag_mem[lookup_index][w] == lookup_tag) begin
        lookup_hit = 1'b1;
        hit_way    = way_t'(w);
      end
    end
  end

  // victim: lowest invalid way, else lru
  always_comb begin
    free_found = 1'b0;
    victim_way = lru[lookup_index];
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (!free_found && !valid[lookup_index][w]) begin
        free_found = 1'b1;
        victim_way = way_t'(w);
      end
    end
  end

  assign victim_dirty = valid[lookup_index][victim_way] && dirty[lookup_index][victim_way];
  assign victim_tag   = tag_mem[lookup_index][victim_way];
  assign victim_line  = line_mem[lookup_index][victim_way];
  assign hit_line     = line_mem[lookup_index][hit_way];

  // payload storage
  always_ff @(posedge clk) begin
    if (fill_en) begin
      line_mem[lookup_index][fill_way] <= fill_line;
      tag_mem[lookup_index][fill_way]  <= lookup_tag;
    end else if (word_wr_en) begin
      line_mem[lookup_index][word_way][int'(word_offset)*$bits(word_t) +: $bits(word_t)]
        <= word_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        lru[s] <= '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          valid[s][w] <= 1'b0;
          dirty[s][w] <= 1'b0;
        end
      end
    end else begin
      if (fill_en) begin
        valid[lookup_index][fill_way] <= 1'b1;
        dirty[lookup_index][fill_way] <= 1'b0;  // fresh line is clean
      end else if (word_wr_en) begin
        dirty[lookup_index][word_way] <= 1'b1;
      end
      if (touch_en)
        lru[lookup_index] <= ~touch_way;  // other way becomes lru
    end
  end

  // controller must never fill and merge on the same edge
  a_fill_word_excl: assert property (@(posedge clk) disable iff (reset)
    !(fill_en && word_wr_en));

endmodule

// File: src/cache_ctrl.sv
module cache_ctrl (
  input  logic                clk,
  input  logic                reset,
  // processor side
  input  logic                in_valid,
  input  cache_pkg::addr_t    addr,
  input  logic                write,
  input  cache_pkg::word_t    wdata,
  output logic                ready,
  output logic                out_valid,
  output cache_pkg::word_t    rdata,
  output logic                hit,
  // memory side
  mem_if.ctrl                 mem,
  // arrays
  output cache_pkg::index_t   lookup_index,
  output cache_pkg::tag_t     lookup_tag,
  input  cache_pkg::way_t     hit_way,
  input  logic                lookup_hit,
  input  cache_pkg::way_t     victim_way,
  input  logic                victim_dirty,
  input  cache_pkg::tag_t     victim_tag,
  input  cache_pkg::line_t    hit_line,
  input  cache_pkg::line_t    victim_line,
  output logic                fill_en,
  output cache_pkg::way_t     fill_way,
  output cache_pkg::line_t    fill_line,
  output logic                word_wr_en,
  output cache_pkg::way_t     word_way,
  output cache_pkg::offset_t  word_offset,
  output cache_pkg::word_t    word_data,
  output logic                touch_en,
  output cache_pkg::way_t     touch_way
);
  import cache_pkg::*;

  localparam int OFF_LSB = 2;  // skip byte-in-word bits
  localparam int IDX_LSB = OFF_LSB + $bits(offset_t);

  cache_state_t state, next_state;

  addr_t addr_q;     // accepted request
  logic  write_q;
  word_t wdata_q;
  way_t  way_q;      // victim chosen at lookup, reused by fill and update
  logic  req_sent;   // fetch already accepted by memory
  word_t hit_word;

  assign lookup_index = addr_q[IDX_LSB +: $bits(index_t)];
  assign lookup_tag   = addr_q[$bits(addr_t)-1 -: $bits(tag_t)];
  assign word_offset  = addr_q[OFF_LSB +: $bits(offset_t)];
  assign word_data    = wdata_q;
  assign fill_way     = way_q;
  assign fill_line    = mem.resp_data;
  assign hit_word     = hit_line[int'(word_offset)*$bits(word_t) +: $bits(word_t)];

  // held low through the response cycle
  assign ready = (state == st_idle) && !out_valid;

  always_comb begin
    next_state    = state;
    mem.req_valid = 1'b0;
    mem.req_write = 1'b0;
    mem.req_line  = {lookup_tag, lookup_index};
    mem.req_data  = victim_line;
    fill_en       = 1'b0;
    word_wr_en    = 1'b0;
    touch_en      = 1'b0;
    word_way      = hit_way;
    touch_way     = hit_way;
    case (state)
      st_idle: begin
        if (in_valid && ready)
          next_state = st_lookup;
      end
      st_lookup: begin
        if (lookup_hit) begin
          touch_en   = 1'b1;
          word_wr_en = write_q;  // write hit merges now
          next_state = st_idle;
        end else if (victim_dirty) begin
          next_state = st_writeback;
        end else begin
          next_state = st_fill;
        end
      end
      st_writeback: begin
        mem.req_valid = 1'b1;
        mem.req_write = 1'b1;
        mem.req_line  = {victim_tag, lookup_index};  // victim's own line address
        if (mem.mem_ready)
          next_state = st_fill;
      end
      st_fill: begin
        mem.req_valid = !req_sent;
        if (mem.resp_valid) begin
          fill_en    = 1'b1;
          next_state = st_update;
        end
      end
      st_update: begin
        // line is in place now, finish like a hit on way_q
        word_wr_en = write_q;
        word_way   = way_q;
        touch_en   = 1'b1;
        touch_way  = way_q;
        next_state = st_idle;
      end
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      out_valid <= 1'b0;
      hit       <= 1'b0;
      req_sent  <= 1'b0;
    end else begin
      state     <= next_state;
      out_valid <= 1'b0;  // single-cycle pulse
      if (state == st_lookup && lookup_hit) begin
        out_valid <= 1'b1;
        hit       <= 1'b1;
      end else if (state == st_update) begin
        out_valid <= 1'b1;
        hit       <= 1'b0;
      end
      if (state != st_fill)
        req_sent <= 1'b0;
      else if (mem.req_valid && mem.mem_ready)
        req_sent <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && ready) begin
      addr_q  <= addr;
      write_q <= write;
      wdata_q <= wdata;
    end
    if (state == st_lookup && !lookup_hit)
      way_q <= victim_way;
    if ((state == st_lookup && lookup_hit) || state == st_update)
      rdata <= write_q ? wdata_q : hit_word;  // writes echo the new word
  end

  a_no_req_idle: assert property (@(posedge clk) disable iff (reset)
    state == st_idle |-> !mem.req_valid);

  a_ready_idle_only: assert property (@(posedge clk) disable iff (reset)
    state != st_idle |-> !ready);

endmodule

// File: src/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // address fields, low to high: byte in word, word in line, set, tag
  typedef logic [$clog2(`LINE_WORDS)-1:0] offset_t;
  typedef logic [$clog2(`CACHE_SETS)-1:0] index_t;
  typedef logic [$bits(addr_t)-$bits(index_t)-$bits(offset_t)-3:0] tag_t;

  typedef logic [`LINE_WORDS*$bits(word_t)-1:0] line_t;  // word 0 in low bits

  typedef logic [$bits(tag_t)+$bits(index_t)-1:0] line_addr_t;  // {tag, index}

  typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_writeback,
    st_fill,
    st_update
  } cache_state_t;

endpackage

// File: src/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry
`define CACHE_SETS 8    // sets, indexed by addr[6:4]
`define CACHE_WAYS 2    // lru is one bit per set, so two ways only
`define LINE_WORDS 4    // 32-bit words per 16-byte line

// backing store
`define MEM_LINES 256   // line addresses wrap above this

// cycles from an accepted request until the read line comes back;
// mem_ready stays low for the same span
`define MEM_LATENCY 4

`endif

// File: src/cache_top.sv
module cache_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        in_valid,
  input  logic [31:0] addr,
  input  logic        write,
  input  logic [31:0] wdata,
  output logic        ready,
  output logic        out_valid,
  output logic [31:0] rdata,
  output logic        hit
);
  import cache_pkg::*;

  index_t  lookup_index;
  tag_t    lookup_tag;
  way_t    hit_way;
  logic    lookup_hit;
  way_t    victim_way;
  logic    victim_dirty;
  tag_t    victim_tag;
  line_t   hit_line;
  line_t   victim_line;
  logic    fill_en;
  way_t    fill_way;
  line_t   fill_line;
  logic    word_wr_en;
  way_t    word_way;
  offset_t word_offset;
  word_t   word_data;
  logic    touch_en;
  way_t    touch_way;

  mem_if mem_bus ();

  cache_ctrl ctrl_i (
    .clk, .reset,
    .in_valid, .addr, .write, .wdata,
    .ready, .out_valid, .rdata, .hit,
    .mem (mem_bus.ctrl),
    .lookup_index, .lookup_tag, .hit_way, .lookup_hit,
    .victim_way, .victim_dirty, .victim_tag, .hit_line, .victim_line,
    .fill_en, .fill_way, .fill_line,
    .word_wr_en, .word_way, .word_offset, .word_data,
    .touch_en, .touch_way
  );

  cache_arrays arrays_i (
    .clk, .reset,
    .lookup_index, .lookup_tag, .hit_way, .lookup_hit,
    .victim_way, .victim_dirty, .victim_tag, .hit_line, .victim_line,
    .fill_en, .fill_way, .fill_line,
    .word_wr_en, .word_way, .word_offset, .word_data,
    .touch_en, .touch_way
  );

  data_memory mem_i (
    .clk, .reset,
    .bus (mem_bus.mem)
  );

endmodule

// File: src/data_memory.sv
`include "cache_settings.svh"

module data_memory (
  input logic clk,
  input logic reset,
  mem_if.mem  bus
);
  import cache_pkg::*;

  localparam int IDX_W      = $clog2(`MEM_LINES);
  localparam int LINE_BYTES = `LINE_WORDS * $bits(word_t) / 8;
  localparam int CNT_W      = $clog2(`MEM_LATENCY + 1);

  line_t            mem [`MEM_LINES];
  logic [CNT_W-1:0] count;    // cycles left on the current request
  logic             read_q;   // current request is a fetch
  logic [IDX_W-1:0] line_q;
  logic [IDX_W-1:0] req_idx;

  // every word starts out holding its own byte address
  initial begin
    for (int l = 0; l < `MEM_LINES; l++)
      for (int w = 0; w < `LINE_WORDS; w++)
        mem[l][w*$bits(word_t) +: $bits(word_t)] = word_t'(l*LINE_BYTES + w*4);
  end

  assign req_idx       = bus.req_line[IDX_W-1:0];  // wraps modulo MEM_LINES
  assign bus.mem_ready = (count == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      count          <= '0;
      read_q         <= 1'b0;
      bus.resp_valid <= 1'b0;
    end else begin
      bus.resp_valid <= 1'b0;
      if (bus.req_valid && bus.mem_ready) begin
        count  <= CNT_W'(`MEM_LATENCY);
        read_q <= !bus.req_write;
      end else if (count != '0) begin
        count <= count - 1'b1;
        if (count == CNT_W'(1) && read_q)
          bus.resp_valid <= 1'b1;  // lands exactly MEM_LATENCY after accept
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.req_valid && bus.mem_ready) begin
      line_q <= req_idx;
      if (bus.req_write)
        mem[req_idx] <= bus.req_data;
    end
    if (count == CNT_W'(1))
      bus.resp_data <= mem[line_q];
  end

  a_resp_on_read_end: assert property (@(posedge clk) disable iff (reset)
    $rose(bus.resp_valid) |-> $past(count == CNT_W'(1) && read_q));

endmodule

// File: src/mem_if.sv
interface mem_if;
  import cache_pkg::*;

  logic       req_valid;
  logic       req_write;   // 1 = line write-back, 0 = line fetch
  line_addr_t req_line;
  line_t      req_data;

  logic       mem_ready;   // low while a request is in flight
  logic       resp_valid;  // one-cycle pulse for a fetch
  line_t      resp_data;

  modport ctrl (
    output req_valid, req_write, req_line, req_data,
    input  mem_ready, resp_valid, resp_data
  );

  modport mem (
    input  req_valid, req_write, req_line, req_data,
    output mem_ready, resp_valid, resp_data
  );

endinterface

// File: verilog.f
+incdir+src
src/cache_pkg.sv
src/mem_if.sv
src/cache_arrays.sv
src/cache_ctrl.sv
src/data_memory.sv
src/cache_top.sv
bench/cache_tb.sv
